// ==== hw/linkPkg.sv ====
package linkPkg;

    // ======================================================================
    // Serial link and FIFO sizing
    // ======================================================================

    // Width of every byte on the link and in the FIFOs
    localparam int ByteW = 8;

    // Command FIFO depth, also the number of command credits at reset
    localparam int CmdDepth = 8;

    // Response FIFO depth, also the number of response credits at reset
    localparam int RspDepth = 16;

    // Flops per serial input in the pin synchronizer
    localparam int SyncStages = 2;

    // Credit counter widths, wide enough to hold the full depth
    localparam int CmdCntW = $clog2(CmdDepth + 1);
    localparam int RspCntW = $clog2(RspDepth + 1);

endpackage

// ==== hw/cmdPkg.sv ====
package cmdPkg;

    // ======================================================================
    // Host command set
    // ======================================================================

    typedef enum logic [7:0] {
        OpNop      = 8'h00,
        OpLedOff   = 8'h80,
        OpLedOn    = 8'h81,
        OpReadMem  = 8'h82,
        OpWriteMem = 8'h83
    } opcodeT;

    // Single payload byte returned for an unknown opcode
    localparam logic [7:0] ErrCode = 8'hEE;

    // ======================================================================
    // Controller FSM
    // ======================================================================

    typedef enum logic [2:0] {
        StFetch,
        StGetAddr,
        StGetArg,
        StExec,
        StSendLen,
        StSendData
    } ctrlStateT;

endpackage

// ==== hw/byteFifo.sv ====
`timescale 1ns/1ps

module byteFifo #(
    parameter int Depth = linkPkg::CmdDepth
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      push,
    input  logic [linkPkg::ByteW-1:0] pushData,
    input  logic                      pop,
    output logic [linkPkg::ByteW-1:0] popData,
    output logic                      empty
);
    import linkPkg::*;

    logic [ByteW-1:0]             mem [Depth];
    logic [$clog2(Depth)-1:0]     wrPtr;
    logic [$clog2(Depth)-1:0]     rdPtr;
    logic [$clog2(Depth + 1)-1:0] count;
    logic                         doPop;

    // Writer side never overflows, the credits upstream see to that
    assign doPop = pop && !empty;
    assign empty = (count == '0);

    // Show-ahead head of queue
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (int'(wrPtr) == Depth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (int'(rdPtr) == Depth - 1) ? '0 : rdPtr + 1'b1;
            end
            case ({push, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/serialRx.sv ====
`timescale 1ns/1ps

module serialRx (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      debugClk,
    input  logic                      debugCs,
    input  logic                      debugDi,
    input  logic                      cmdCredit,
    output logic                      cmdPush,
    output logic [linkPkg::ByteW-1:0] cmdPushData,
    output logic                      cmdOverrun,
    output logic                      bitTick,
    output logic [2:0]                bitIndex
);
    import linkPkg::*;

    logic [SyncStages-1:0] clkSync;
    logic [SyncStages-1:0] csSync;
    logic [SyncStages-1:0] diSync;
    logic                  clkPrev;
    logic                  csNow;
    logic                  diNow;
    logic [ByteW-1:0]      shiftReg;
    logic [CmdCntW-1:0]    cmdCredits;
    logic                  byteDone;

    assign csNow = csSync[SyncStages-1];
    assign diNow = diSync[SyncStages-1];

    // Rising debugClk edge seen in the clk domain, only while selected
    assign bitTick  = clkSync[SyncStages-1] && !clkPrev && csNow;
    assign byteDone = bitTick && (bitIndex == 3'd7);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            clkSync    <= '0;
            csSync     <= '0;
            diSync     <= '0;
            clkPrev    <= 1'b0;
            bitIndex   <= 3'd0;
            cmdPush    <= 1'b0;
            cmdOverrun <= 1'b0;
            cmdCredits <= CmdCntW'(CmdDepth);
        end else begin
            clkSync <= {clkSync[SyncStages-2:0], debugClk};
            csSync  <= {csSync[SyncStages-2:0], debugCs};
            diSync  <= {diSync[SyncStages-2:0], debugDi};
            clkPrev <= clkSync[SyncStages-1];

            if (!csNow) begin
                bitIndex <= 3'd0;
            end else if (bitTick) begin
                bitIndex <= bitIndex + 3'd1;
            end

            // Drop the byte when the command FIFO has no room for it
            cmdPush <= byteDone && (cmdCredits != '0);
            if (byteDone && (cmdCredits == '0)) begin
                cmdOverrun <= 1'b1;
            end

            case ({cmdPush, cmdCredit})
                2'b10:   cmdCredits <= cmdCredits - 1'b1;
                2'b01:   cmdCredits <= cmdCredits + 1'b1;
                default: cmdCredits <= cmdCredits;
            endcase
        end
    end

    // Bit assembly, MSB first
    always_ff @(posedge clk) begin
        if (bitTick) begin
            shiftReg <= {shiftReg[ByteW-2:0], diNow};
        end
        if (byteDone) begin
            cmdPushData <= {shiftReg[ByteW-2:0], diNow};
        end
    end

endmodule

// ==== hw/serialTx.sv ====
`timescale 1ns/1ps

module serialTx (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      bitTick,
    input  logic [2:0]                bitIndex,
    input  logic                      rspEmpty,
    input  logic [linkPkg::ByteW-1:0] rspData,
    output logic                      rspPop,
    output logic                      debugDo
);
    import linkPkg::*;

    logic [ByteW-1:0] shiftReg;
    logic             loadTick;

    // ======================================================================
    // Byte framing shared with the receiver
    // ======================================================================

    // Host samples the last bit of a byte on this tick, so the next one
    // goes in behind it
    assign loadTick = bitTick && (bitIndex == 3'd7);

    // Each pop frees one slot, which returns to the controller as a credit
    assign rspPop = loadTick && !rspEmpty;

    assign debugDo = shiftReg[ByteW-1];

    // ======================================================================
    // Output shifter
    // ======================================================================

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= '0;
        end else if (loadTick) begin
            // Idle filler is a zero byte
            shiftReg <= rspEmpty ? '0 : rspData;
        end else if (bitTick) begin
            shiftReg <= {shiftReg[ByteW-2:0], 1'b0};
        end
    end

    // A loaded byte stays on the pin while the host is deselected,
    // so its first bit is ready as soon as debugCs rises again

endmodule

// ==== hw/scratchMem.sv ====
`timescale 1ns/1ps

module scratchMem (
    input  logic                      clk,
    input  logic                      memWe,
    input  logic [linkPkg::ByteW-1:0] memAddr,
    input  logic [linkPkg::ByteW-1:0] memWData,
    output logic [linkPkg::ByteW-1:0] memRData
);
    import linkPkg::*;

    // One entry per address value
    logic [ByteW-1:0] mem [2**ByteW];

    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memWData;
        end
        // Registered read, old data on a same-address write
        memRData <= mem[memAddr];
    end

endmodule

// ==== hw/cmdController.sv ====
`timescale 1ns/1ps

module cmdController (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      cmdEmpty,
    input  logic [linkPkg::ByteW-1:0] cmdData,
    output logic                      cmdPop,
    input  logic                      rspCredit,
    output logic                      rspPush,
    output logic [linkPkg::ByteW-1:0] rspPushData,
    output logic                      memWe,
    output logic [linkPkg::ByteW-1:0] memAddr,
    output logic [linkPkg::ByteW-1:0] memWData,
    input  logic [linkPkg::ByteW-1:0] memRData,
    output logic                      led
);
    import linkPkg::*;
    import cmdPkg::*;

    ctrlStateT          state;
    opcodeT             opReg;
    logic [RspCntW-1:0] rspCredits;
    logic [ByteW-1:0]   addrReg;
    logic [ByteW-1:0]   argReg;
    logic [ByteW-1:0]   lenReg;
    logic [ByteW-1:0]   echoReg;
    logic               haveCredit;
    logic               frameFits;
    logic               isMemOp;
    logic               advance;

    // ======================================================================
    // Decode helpers
    // ======================================================================

    assign isMemOp    = (cmdData == OpReadMem) || (cmdData == OpWriteMem);
    assign haveCredit = (rspCredits != '0);

    // Whole frame (length byte plus payload) fits in the free slots.
    // Frames longer than the FIFO start once it has drained completely
    // and then stream byte by byte as credits come back
    assign frameFits = (int'(rspCredits) > int'(lenReg))
                    || (rspCredits == RspCntW'(RspDepth));

    // Read pointer moves only on a payload push
    assign advance = (state == StSendData) && rspPush;

    // ======================================================================
    // Memory port
    // ======================================================================

    // addrReg always names the byte now on memRData while streaming
    assign memAddr  = addrReg + {{(ByteW - 1){1'b0}}, advance};
    assign memWData = argReg;
    assign memWe    = (state == StExec) && (opReg == OpWriteMem);

    // ======================================================================
    // Queue handshakes
    // ======================================================================

    always_comb begin
        cmdPop      = 1'b0;
        rspPush     = 1'b0;
        rspPushData = lenReg;
        case (state)
            StFetch, StGetAddr, StGetArg: begin
                cmdPop = !cmdEmpty;
            end
            StSendLen: begin
                // frameFits already implies a nonzero credit count
                rspPush = frameFits;
            end
            StSendData: begin
                rspPush     = haveCredit;
                rspPushData = (opReg == OpReadMem) ? memRData : echoReg;
            end
            default: begin
                cmdPop = 1'b0;
            end
        endcase
    end

    // ======================================================================
    // FSM, LED and response credits
    // ======================================================================

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= StFetch;
            opReg      <= OpNop;
            led        <= 1'b0;
            rspCredits <= RspCntW'(RspDepth);
        end else begin
            case ({rspPush, rspCredit})
                2'b10:   rspCredits <= rspCredits - 1'b1;
                2'b01:   rspCredits <= rspCredits + 1'b1;
                default: rspCredits <= rspCredits;
            endcase

            case (state)
                StFetch: begin
                    if (!cmdEmpty) begin
                        opReg <= opcodeT'(cmdData);
                        if (isMemOp) begin
                            state <= StGetAddr;
                        end else if (cmdData != OpNop) begin
                            state <= StExec;
                        end
                    end
                end
                StGetAddr: begin
                    if (!cmdEmpty) begin
                        state <= StGetArg;
                    end
                end
                StGetArg: begin
                    if (!cmdEmpty) begin
                        state <= StExec;
                    end
                end
                StExec: begin
                    state <= StSendLen;
                    case (opReg)
                        OpLedOff: led <= 1'b0;
                        OpLedOn:  led <= 1'b1;
                        OpReadMem: begin
                            // Zero count has no frame at all
                            if (argReg == '0) begin
                                state <= StFetch;
                            end
                        end
                        default: led <= led;
                    endcase
                end
                StSendLen: begin
                    if (frameFits) begin
                        state <= StSendData;
                    end
                end
                StSendData: begin
                    if (haveCredit && (lenReg == 8'd1)) begin
                        state <= StFetch;
                    end
                end
                default: begin
                    state <= StFetch;
                end
            endcase
        end
    end

    // Operands and frame bookkeeping
    always_ff @(posedge clk) begin
        case (state)
            StGetAddr: begin
                if (!cmdEmpty) begin
                    addrReg <= cmdData;
                end
            end
            StGetArg: begin
                if (!cmdEmpty) begin
                    argReg <= cmdData;
                end
            end
            StExec: begin
                lenReg <= (opReg == OpReadMem) ? argReg : 8'd1;
                case (opReg)
                    OpLedOff, OpLedOn, OpWriteMem: echoReg <= opReg;
                    default:                       echoReg <= ErrCode;
                endcase
            end
            StSendData: begin
                // lenReg counts the payload bytes still to go
                if (rspPush) begin
                    lenReg <= lenReg - 1'b1;
                end
                addrReg <= memAddr;
            end
            default: begin
                addrReg <= addrReg;
            end
        endcase
    end

endmodule

// ==== hw/debugLinkTop.sv ====
`timescale 1ns/1ps

module debugLinkTop (
    input  logic clk,
    input  logic rstN,
    input  logic debugClk,
    input  logic debugCs,
    input  logic debugDi,
    output logic debugDo,
    output logic led,
    output logic cmdOverrun
);
    import linkPkg::*;

    logic             cmdPush;
    logic [ByteW-1:0] cmdPushData;
    logic             cmdPop;
    logic [ByteW-1:0] cmdHead;
    logic             cmdEmpty;
    logic             rspPush;
    logic [ByteW-1:0] rspPushData;
    logic             rspPop;
    logic [ByteW-1:0] rspHead;
    logic             rspEmpty;
    logic             memWe;
    logic [ByteW-1:0] memAddr;
    logic [ByteW-1:0] memWData;
    logic [ByteW-1:0] memRData;
    logic             bitTick;
    logic [2:0]       bitIndex;

    // ======================================================================
    // Host to controller
    // ======================================================================

    serialRx u_serialRx (
        .clk         (clk),
        .rstN        (rstN),
        .debugClk    (debugClk),
        .debugCs     (debugCs),
        .debugDi     (debugDi),
        .cmdCredit   (cmdPop),
        .cmdPush     (cmdPush),
        .cmdPushData (cmdPushData),
        .cmdOverrun  (cmdOverrun),
        .bitTick     (bitTick),
        .bitIndex    (bitIndex)
    );

    byteFifo #(.Depth(CmdDepth)) cmdFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (cmdPush),
        .pushData (cmdPushData),
        .pop      (cmdPop),
        .popData  (cmdHead),
        .empty    (cmdEmpty)
    );

    cmdController u_cmdController (
        .clk         (clk),
        .rstN        (rstN),
        .cmdEmpty    (cmdEmpty),
        .cmdData     (cmdHead),
        .cmdPop      (cmdPop),
        .rspCredit   (rspPop),
        .rspPush     (rspPush),
        .rspPushData (rspPushData),
        .memWe       (memWe),
        .memAddr     (memAddr),
        .memWData    (memWData),
        .memRData    (memRData),
        .led         (led)
    );

    scratchMem u_scratchMem (
        .clk      (clk),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRData (memRData)
    );

    // ======================================================================
    // Controller to host
    // ======================================================================

    byteFifo #(.Depth(RspDepth)) rspFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (rspPush),
        .pushData (rspPushData),
        .pop      (rspPop),
        .popData  (rspHead),
        .empty    (rspEmpty)
    );

    serialTx u_serialTx (
        .clk      (clk),
        .rstN     (rstN),
        .bitTick  (bitTick),
        .bitIndex (bitIndex),
        .rspEmpty (rspEmpty),
        .rspData  (rspHead),
        .rspPop   (rspPop),
        .debugDo  (debugDo)
    );

endmodule

// ==== sim/debugLink_asserts.sv ====
`timescale 1ns/1ps

module debugLinkAsserts #(
    parameter int MaxCredits = linkPkg::CmdDepth,
    parameter int CntW       = linkPkg::CmdCntW
) (
    input logic            clk,
    input logic            rstN,
    input logic            push,
    input logic [CntW-1:0] credits
);

    // Failures seen so far
    int errCount = 0;

    // Credits only come back for slots that were used
    creditLimit: assert property (
        @(posedge clk) disable iff (!rstN) int'(credits) <= MaxCredits
    ) else begin
        errCount++;
        $error("Credit count %0d above its limit %0d", credits, MaxCredits);
    end

    // A push always spends a credit that exists
    pushNeedsCredit: assert property (
        @(posedge clk) disable iff (!rstN) push |-> (credits != '0)
    ) else begin
        errCount++;
        $error("Push issued with no credit left");
    end

endmodule

// ======================================================================
// Response credits, kept by the controller
// ======================================================================

bind cmdController debugLinkAsserts #(
    .MaxCredits (linkPkg::RspDepth),
    .CntW       (linkPkg::RspCntW)
) u_rspAsserts (
    .clk     (clk),
    .rstN    (rstN),
    .push    (rspPush),
    .credits (rspCredits)
);

// ======================================================================
// Command credits, kept by the receiver
// ======================================================================

bind serialRx debugLinkAsserts #(
    .MaxCredits (linkPkg::CmdDepth),
    .CntW       (linkPkg::CmdCntW)
) u_cmdAsserts (
    .clk     (clk),
    .rstN    (rstN),
    .push    (cmdPush),
    .credits (cmdCredits)
);

// ==== sim/tbDebugLink.sv ====
`timescale 1ns/1ps

module tbDebugLink;
    import cmdPkg::*;

    logic       clk;
    logic       rstN;
    logic       debugClk;
    logic       debugCs;
    logic       debugDi;
    logic       debugDo;
    logic       led;
    logic       cmdOverrun;

    // What the fill section wrote, indexed by address
    logic [7:0] memModel [256];
    logic [7:0] fillBase;
    integer     seed;

    debugLinkTop u_debugLinkTop (
        .clk        (clk),
        .rstN       (rstN),
        .debugClk   (debugClk),
        .debugCs    (debugCs),
        .debugDi    (debugDi),
        .debugDo    (debugDo),
        .led        (led),
        .cmdOverrun (cmdOverrun)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ======================================================================
    // Failure reporting and checks
    // ======================================================================

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        abortRun();
    endtask

    task automatic checkValue(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
        if (got !== expected) begin
            $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, expected);
            abortRun();
        end
    endtask

    // Bound credit checks on both queues
    always @(posedge clk) begin
        if ((u_debugLinkTop.u_cmdController.u_rspAsserts.errCount
             + u_debugLinkTop.u_serialRx.u_cmdAsserts.errCount) != 0) begin
            reportFailure("A bound credit assertion failed");
        end
    end

    // ======================================================================
    // Host side of the serial link
    // ======================================================================

    // Lands 10 ns after a rising clk edge
    task automatic stepCycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // One byte each way, MSB first, six clk cycles per debugClk half-period
    task automatic transferByte(input logic [7:0] txByte, output logic [7:0] rxByte);
        for (int i = 7; i >= 0; i--) begin
            debugDi = txByte[i];
            stepCycles(6);
            // debugDo moved a few cycles after the last edge, stable by now
            rxByte[i] = debugDo;
            debugClk  = 1'b1;
            stepCycles(6);
            debugClk  = 1'b0;
        end
    endtask

    // Clocks Nops until a nonzero length byte, gives 0 after 64 idle bytes
    task automatic awaitFrame(output logic [7:0] frameLen);
        logic [7:0] rxByte;
        int         tries;
        frameLen = 8'h00;
        tries    = 0;
        while ((frameLen == 8'h00) && (tries < 64)) begin
            transferByte(OpNop, rxByte);
            frameLen = rxByte;
            tries++;
        end
    endtask

    task automatic checkFrame(input logic [7:0] expected);
        logic [7:0] frameLen;
        awaitFrame(frameLen);
        if ((frameLen == 8'h00) && (expected != 8'h00)) begin
            reportFailure("No response frame arrived within 64 bytes");
        end else begin
            checkValue("frameLen", frameLen, expected);
        end
    endtask

    task automatic readPayload(input string name, input logic [7:0] expected);
        logic [7:0] rxByte;
        transferByte(OpNop, rxByte);
        checkValue(name, rxByte, expected);
    endtask

    // ======================================================================
    // Random fill section
    // ======================================================================

    // WriteMem with random data at fillBase onwards, each echo checked
    task automatic writeRandomFill(input int count);
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] rxByte;
        for (int i = 0; i < count; i++) begin
            addr           = fillBase + 8'(i);
            data           = 8'($random(seed));
            memModel[addr] = data;
            transferByte(OpWriteMem, rxByte);
            transferByte(addr, rxByte);
            transferByte(data, rxByte);
            checkFrame(8'h01);
            readPayload("writeEcho", OpWriteMem);
        end
    endtask

    // Payload of a read that starts at fillBase, address wraps at 256
    task automatic readFromModel(input int count);
        logic [7:0] addr;
        for (int i = 0; i < count; i++) begin
            addr = fillBase + 8'(i);
            readPayload("memData", memModel[addr]);
        end
    endtask

    task automatic runOperation(input string op, input logic [7:0] value,
                                inout logic done);
        logic [7:0] rxByte;
        case (op)
            "S": transferByte(value, rxByte);
            "F": checkFrame(value);
            "D": readPayload("rspData", value);
            "R": readFromModel(int'(value));
            "L": checkValue("led", {7'b0, led}, value);
            "O": checkValue("cmdOverrun", {7'b0, cmdOverrun}, value);
            "A": fillBase = value;
            "W": writeRandomFill(int'(value));
            "E": done = 1'b1;
            default: reportFailure($sformatf("Unknown operation %s in stimulus file", op));
        endcase
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        int         fd;
        int         code;
        int         assertFails;
        string      op;
        string      restOfLine;
        logic [7:0] value;
        logic       done;

        rstN     = 1'b0;
        debugClk = 1'b0;
        debugCs  = 1'b0;
        debugDi  = 1'b0;
        seed     = 32'hd694;
        fillBase = 8'h00;
        done     = 1'b0;

        repeat (3) @(posedge clk);
        #10;
        rstN = 1'b1;
        stepCycles(2);
        // Host stays selected for the whole session
        debugCs = 1'b1;
        stepCycles(4);

        fd = $fopen("sim/debug_stimulus.txt", "r");
        if (fd == 0) begin
            reportFailure("Cannot open sim/debug_stimulus.txt");
        end
        while (!done) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                reportFailure("Stimulus file ended before its E line");
            end else if (op.getc(0) == "#") begin
                code = $fgets(restOfLine, fd);
            end else begin
                code = $fscanf(fd, "%h", value);
                if (code != 1) begin
                    reportFailure($sformatf("Operation %s has no hex value", op));
                end else begin
                    runOperation(op, value, done);
                end
            end
        end
        $fclose(fd);

        assertFails = u_debugLinkTop.u_cmdController.u_rspAsserts.errCount
                    + u_debugLinkTop.u_serialRx.u_cmdAsserts.errCount;
        if (assertFails != 0) begin
            $display("Bound assertions failed %0d times", assertFails);
            $display("SOME TESTS FAILED");
            $fatal(1, "Assertion failures during the run");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== src.f ====
hw/linkPkg.sv
hw/cmdPkg.sv
hw/byteFifo.sv
hw/serialRx.sv
hw/serialTx.sv
hw/scratchMem.sv
hw/cmdController.sv
hw/debugLinkTop.sv
sim/debugLink_asserts.sv
sim/tbDebugLink.sv

// ==== Bender.yml ====
package:
  name: debug_link

sources:
  # Packages first, then the datapath and the top level
  - files:
      - hw/linkPkg.sv
      - hw/cmdPkg.sv
      - hw/byteFifo.sv
      - hw/serialRx.sv
      - hw/serialTx.sv
      - hw/scratchMem.sv
      - hw/cmdController.sv
      - hw/debugLinkTop.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/debugLink_asserts.sv
      - sim/tbDebugLink.sv

// ==== sim/debug_stimulus.txt ====
# Columns: operation letter, hex value. S send, F frame length, D payload byte,
# R n bytes from fill model, L led, O cmdOverrun, A fill base, W n random writes, E end
# LED on and off, echoed opcode each time
S 81
F 01
D 81
L 01
S 80
F 01
D 80
L 00
# Writes at fixed addresses
S 83
S 10
S 5A
F 01
D 83
S 83
S 11
S A5
F 01
D 83
# Read both back
S 82
S 10
S 02
F 02
D 5A
D A5
# Unknown opcode
S 42
F 01
D EE
# Nops alone give no frame
S 00
F 00
# Zero count read gives no frame either
S 82
S 10
S 00
F 00
# Random fill across the wrap point
A F0
W 28
O 00
# Read longer than the response FIFO
S 82
S F0
S 28
F 28
R 28
# Nop reads during the stream outrun the command FIFO
O 01
S 81
F 01
D 81
L 01
E 00
